// File: source/conv_geometry_pkg.sv
`default_nettype none

package conv_geometry_pkg;

	// Image, kernel and channel sizes
	localparam int image_width = 8;
	localparam int image_height = 8;
	localparam int kernel_size = 3;
	localparam int kernel_area = kernel_size * kernel_size;
	localparam int channel_num_in = 2;
	localparam int channel_num_out = 2;

	// Valid convolution loses kernel_size - 1 on each axis
	localparam int out_width = image_width - kernel_size + 1;
	localparam int out_height = image_height - kernel_size + 1;

	localparam int image_size = image_width * image_height;
	localparam int frame_words = channel_num_in * image_size;
	localparam int weight_words = channel_num_out * channel_num_in * kernel_area;
	localparam int replay_words = channel_num_out * frame_words;
	localparam int out_size = out_width * out_height;
	localparam int out_total = channel_num_out * out_size;

	// Counter widths, image sides are powers of two
	localparam int row_w = $clog2(image_height);
	localparam int col_w = $clog2(image_width);
	localparam int ch_in_w = $clog2(channel_num_in);
	localparam int ch_out_w = $clog2(channel_num_out);
	localparam int pix_addr_w = $clog2(frame_words);
	localparam int wt_addr_w = $clog2(weight_words);
	localparam int rep_w = $clog2(replay_words);
	localparam int out_row_w = $clog2(out_height);
	localparam int out_col_w = $clog2(out_width);
	localparam int out_addr_w = $clog2(out_size);
	localparam int out_cnt_w = $clog2(out_total);

endpackage

`default_nettype wire

// File: source/conv_types_pkg.sv
`default_nettype none

package conv_types_pkg;
	import conv_geometry_pkg::*;

	////////////////////////////////////////////////////////////
	// Data words

	typedef logic signed [7:0] pixel_t;
	typedef logic signed [7:0] weight_t;
	typedef logic signed [15:0] product_t;

	// Holds 18 worst case products without overflow
	typedef logic signed [19:0] accum_t;

	////////////////////////////////////////////////////////////
	// Structs passed between blocks

	// Position of one pixel in the replay stream
	typedef struct packed {
		logic valid;
		logic [ch_in_w-1:0] ch_in;
		logic [ch_out_w-1:0] ch_out;
		logic [row_w-1:0] row;
		logic [col_w-1:0] col;
	} conv_tag_t;

	// Named by row then column, top left is the MSB field
	typedef struct packed {
		weight_t k00, k01, k02;
		weight_t k10, k11, k12;
		weight_t k20, k21, k22;
	} kernel_t;

	typedef struct packed {
		pixel_t p00, p01, p02;
		pixel_t p10, p11, p12;
		pixel_t p20, p21, p22;
	} window_t;

	typedef struct packed {
		logic valid;
		logic [ch_in_w-1:0] ch_in;
		logic [ch_out_w-1:0] ch_out;
		logic [out_row_w-1:0] out_row;
		logic [out_col_w-1:0] out_col;
		accum_t sum;
	} mac_beat_t;

endpackage

`default_nettype wire

// File: source/conv_sequencer.sv
`default_nettype none

module conv_sequencer import conv_geometry_pkg::*, conv_types_pkg::*; (
	input logic clk,
	input logic reset,
	input logic valid_in,
	input logic valid_weight_in,
	output logic pix_wr_en,
	output logic [pix_addr_w-1:0] pix_wr_addr,
	output logic [pix_addr_w-1:0] rd_addr,
	output conv_tag_t tag,
	output logic wt_wr_en,
	output logic [wt_addr_w-1:0] wt_wr_addr,
	output logic [ch_out_w-1:0] kernel_sel_out,
	output logic [ch_in_w-1:0] kernel_sel_in,
	input logic mac_last,
	output logic done
);

	typedef enum logic [1:0] {
		st_idle,
		st_loading,
		st_replaying
	} seq_state_t;

	seq_state_t state;
	logic [rep_w:0] rep_cnt;
	logic [rep_w-1:0] rep_pos;
	logic replay_rd;
	logic [out_cnt_w-1:0] out_cnt;

	// Weights only between frames, pixels until the image is complete
	assign wt_wr_en = valid_weight_in && (state == st_idle);
	assign pix_wr_en = valid_in && (state != st_replaying);

	// Top bit of rep_cnt marks the end of the replay
	assign replay_rd = (state == st_replaying) && !rep_cnt[rep_w];
	assign rep_pos = rep_cnt[rep_w-1:0];
	assign rd_addr = rep_pos[pix_addr_w-1:0];

	// Kernel follows the delayed tag so it changes with the plane's own windows
	assign kernel_sel_out = tag.ch_out;
	assign kernel_sel_in = tag.ch_in;

	////////////////////////////////////////////////////////////
	// Load, replay and output counting

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			pix_wr_addr <= '0;
			wt_wr_addr <= '0;
			rep_cnt <= '0;
			out_cnt <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (wt_wr_en) begin
				wt_wr_addr <= (wt_wr_addr == wt_addr_w'(weight_words - 1)) ?
					'0 : wt_wr_addr + 1'b1;
			end
			// Wraps back to zero after the last word of the frame
			if (pix_wr_en)
				pix_wr_addr <= pix_wr_addr + 1'b1;
			if (replay_rd)
				rep_cnt <= rep_cnt + 1'b1;
			case (state)
				st_idle: begin
					if (pix_wr_en)
						state <= st_loading;
				end
				st_loading: begin
					if (pix_wr_en && pix_wr_addr == pix_addr_w'(frame_words - 1)) begin
						state <= st_replaying;
						rep_cnt <= '0;
						out_cnt <= '0;
					end
				end
				st_replaying: begin
					if (mac_last) begin
						out_cnt <= out_cnt + 1'b1;
						if (out_cnt == out_cnt_w'(out_total - 1)) begin
							state <= st_idle;
							done <= 1'b1;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Tag, one cycle behind the read address like the memory data

	always_ff @(posedge clk) begin
		if (reset) begin
			tag <= '0;
		end else begin
			tag.valid <= replay_rd;
			tag.ch_out <= rep_pos[pix_addr_w +: ch_out_w];
			tag.ch_in <= rep_pos[row_w + col_w +: ch_in_w];
			tag.row <= rep_pos[col_w +: row_w];
			tag.col <= rep_pos[col_w-1:0];
		end
	end

endmodule

`default_nettype wire

// File: source/input_replay_buffer.sv
`default_nettype none

module input_replay_buffer import conv_geometry_pkg::*, conv_types_pkg::*; (
	input logic clk,
	input logic wr_en,
	input logic [pix_addr_w-1:0] wr_addr,
	input pixel_t pxl_in,
	input logic [pix_addr_w-1:0] rd_addr,
	output pixel_t pxl_out
);

	// Whole image, all input planes
	pixel_t mem [frame_words];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= pxl_in;
		pxl_out <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// File: source/line_window.sv
`default_nettype none

module line_window import conv_geometry_pkg::*, conv_types_pkg::*; (
	input logic clk,
	input logic reset,
	input pixel_t pxl_in,
	input conv_tag_t tag_in,
	output window_t window,
	output conv_tag_t tag_out
);

	// One image row of delay each, line_2 follows line_1
	pixel_t line_1 [image_width];
	pixel_t line_2 [image_width];

	always_ff @(posedge clk) begin
		if (tag_in.valid) begin
			line_1[0] <= pxl_in;
			line_2[0] <= line_1[image_width-1];
			for (int i = 1; i < image_width; i++) begin
				line_1[i] <= line_1[i-1];
				line_2[i] <= line_2[i-1];
			end

			// Columns move left, the new column enters on the right
			window.p00 <= window.p01;
			window.p01 <= window.p02;
			window.p02 <= line_2[image_width-1];
			window.p10 <= window.p11;
			window.p11 <= window.p12;
			window.p12 <= line_1[image_width-1];
			window.p20 <= window.p21;
			window.p21 <= window.p22;
			window.p22 <= pxl_in;
		end
	end

	// Valid only once the window sits fully inside one plane
	always_ff @(posedge clk) begin
		if (reset) begin
			tag_out <= '0;
		end else begin
			tag_out <= tag_in;
			tag_out.valid <= tag_in.valid &&
				(tag_in.row >= kernel_size - 1) &&
				(tag_in.col >= kernel_size - 1);
		end
	end

endmodule

`default_nettype wire

// File: source/weight_store.sv
`default_nettype none

module weight_store import conv_geometry_pkg::*, conv_types_pkg::*; (
	input logic clk,
	input logic wr_en,
	input logic [wt_addr_w-1:0] wr_addr,
	input weight_t weight_in,
	input logic [ch_out_w-1:0] sel_out,
	input logic [ch_in_w-1:0] sel_in,
	output kernel_t kernel
);

	weight_t mem [weight_words];
	weight_t [kernel_area-1:0] kern_q;
	logic [wt_addr_w-1:0] base;

	// Kernels are stored by output channel, then input channel
	assign base = wt_addr_w'((sel_out * channel_num_in + sel_in) * kernel_area);
	assign kernel = kern_q;

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= weight_in;
		// First word of the kernel lands in the top left field
		for (int i = 0; i < kernel_area; i++) begin
			kern_q[kernel_area-1-i] <= mem[base + i];
		end
	end

endmodule

`default_nettype wire

// File: source/mac_array.sv
`default_nettype none

module mac_array import conv_geometry_pkg::*, conv_types_pkg::*; (
	input logic clk,
	input logic reset,
	input window_t window,
	input kernel_t kernel,
	input conv_tag_t tag,
	output mac_beat_t beat
);

	pixel_t [kernel_area-1:0] px;
	weight_t [kernel_area-1:0] wt;
	product_t prod [kernel_area];
	conv_tag_t tag_q;
	accum_t sum;

	// Same field order in both, so index i pairs pixel and weight
	assign px = window;
	assign wt = kernel;

	// Stage 1, nine products
	always_ff @(posedge clk) begin
		for (int i = 0; i < kernel_area; i++) begin
			prod[i] <= product_t'(px[i]) * product_t'(wt[i]);
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			tag_q <= '0;
		else
			tag_q <= tag;
	end

	always_comb begin
		sum = '0;
		for (int i = 0; i < kernel_area; i++) begin
			sum = sum + accum_t'(prod[i]);
		end
	end

	// Stage 2, sum and output coordinates
	always_ff @(posedge clk) begin
		if (reset) begin
			beat <= '0;
		end else begin
			beat.valid <= tag_q.valid;
			beat.ch_in <= tag_q.ch_in;
			beat.ch_out <= tag_q.ch_out;
			beat.out_row <= out_row_w'(tag_q.row - (kernel_size - 1));
			beat.out_col <= out_col_w'(tag_q.col - (kernel_size - 1));
			beat.sum <= sum;
		end
	end

endmodule

`default_nettype wire

// File: source/channel_accumulator.sv
`default_nettype none

module channel_accumulator import conv_geometry_pkg::*, conv_types_pkg::*; (
	input logic clk,
	input logic reset,
	input mac_beat_t beat,
	output logic valid_out,
	output accum_t pxl_out,
	output logic mac_last
);

	// Partial sums of one output channel, indexed by output position
	accum_t psum [out_size];
	logic [out_addr_w-1:0] psum_addr;
	logic first_plane;
	logic last_plane;
	accum_t total;

	assign psum_addr = out_addr_w'(beat.out_row * out_width + beat.out_col);
	assign first_plane = (beat.ch_in == '0);
	assign last_plane = (beat.ch_in == ch_in_w'(channel_num_in - 1));

	// First plane starts the sum, later planes add to it
	assign total = first_plane ? beat.sum : psum[psum_addr] + beat.sum;

	always_ff @(posedge clk) begin
		if (beat.valid)
			psum[psum_addr] <= total;
		if (beat.valid && last_plane)
			pxl_out <= total;
	end

	always_ff @(posedge clk) begin
		if (reset)
			valid_out <= 1'b0;
		else
			valid_out <= beat.valid && last_plane;
	end

	// Output strobe for the frame counter in the sequencer
	assign mac_last = valid_out;

endmodule

`default_nettype wire

// File: source/conv_layer_top.sv
`default_nettype none

module conv_layer_top import conv_geometry_pkg::*, conv_types_pkg::*; (
	input logic clk,
	input logic reset,
	input logic valid_in,
	input pixel_t pxl_in,
	input logic valid_weight_in,
	input weight_t weight_in,
	output accum_t pxl_out,
	output logic valid_out,
	output logic done
);

	logic pix_wr_en;
	logic [pix_addr_w-1:0] pix_wr_addr;
	logic [pix_addr_w-1:0] rd_addr;
	logic wt_wr_en;
	logic [wt_addr_w-1:0] wt_wr_addr;
	logic [ch_out_w-1:0] kernel_sel_out;
	logic [ch_in_w-1:0] kernel_sel_in;
	logic mac_last;
	pixel_t replay_pxl;
	conv_tag_t seq_tag;
	conv_tag_t win_tag;
	window_t window;
	kernel_t kernel;
	mac_beat_t beat;

	////////////////////////////////////////////////////////////
	// Control and storage

	conv_sequencer conv_sequencer_inst (
		.clk(clk),
		.reset(reset),
		.valid_in(valid_in),
		.valid_weight_in(valid_weight_in),
		.pix_wr_en(pix_wr_en),
		.pix_wr_addr(pix_wr_addr),
		.rd_addr(rd_addr),
		.tag(seq_tag),
		.wt_wr_en(wt_wr_en),
		.wt_wr_addr(wt_wr_addr),
		.kernel_sel_out(kernel_sel_out),
		.kernel_sel_in(kernel_sel_in),
		.mac_last(mac_last),
		.done(done)
	);

	input_replay_buffer input_replay_buffer_inst (
		.clk(clk),
		.wr_en(pix_wr_en),
		.wr_addr(pix_wr_addr),
		.pxl_in(pxl_in),
		.rd_addr(rd_addr),
		.pxl_out(replay_pxl)
	);

	weight_store weight_store_inst (
		.clk(clk),
		.wr_en(wt_wr_en),
		.wr_addr(wt_wr_addr),
		.weight_in(weight_in),
		.sel_out(kernel_sel_out),
		.sel_in(kernel_sel_in),
		.kernel(kernel)
	);

	////////////////////////////////////////////////////////////
	// Convolution and channel sum

	line_window line_window_inst (
		.clk(clk),
		.reset(reset),
		.pxl_in(replay_pxl),
		.tag_in(seq_tag),
		.window(window),
		.tag_out(win_tag)
	);

	mac_array mac_array_inst (
		.clk(clk),
		.reset(reset),
		.window(window),
		.kernel(kernel),
		.tag(win_tag),
		.beat(beat)
	);

	channel_accumulator channel_accumulator_inst (
		.clk(clk),
		.reset(reset),
		.beat(beat),
		.valid_out(valid_out),
		.pxl_out(pxl_out),
		.mac_last(mac_last)
	);

endmodule

`default_nettype wire

// File: test/conv_layer_checker.sv
`default_nettype none

module conv_layer_checker import conv_geometry_pkg::*, conv_types_pkg::*; (
	input logic clk,
	input logic reset,
	input logic valid_in,
	input pixel_t pxl_in,
	input logic valid_weight_in,
	input weight_t weight_in,
	input logic valid_out,
	input accum_t pxl_out,
	input logic done,
	output int pass_count,
	output int fail_count,
	output logic timed_out
);

	// Worst case frame is a weight load, a gapped image and the replay
	localparam int frame_cycles = weight_words + frame_words * 4 + 300;
	// Seven full frames and one aborted by reset plus a margin
	localparam int cycle_limit = 8 * frame_cycles;

	int frame [frame_words];
	int weights [weight_words];
	int pix_cnt;
	int wt_ptr;
	int out_idx;
	int cycle_cnt;
	logic busy;
	logic done_q;

	initial begin
		pass_count = 0;
		fail_count = 0;
		cycle_cnt = 0;
		timed_out = 1'b0;
	end

	// Output index runs over output channel, row, then column
	function automatic int expected_pixel(input int index);
		int co;
		int r;
		int c;
		int sum;
		co = index / out_size;
		r = (index % out_size) / out_width;
		c = index % out_width;
		sum = 0;
		for (int ci = 0; ci < channel_num_in; ci++) begin
			for (int ky = 0; ky < kernel_size; ky++) begin
				for (int kx = 0; kx < kernel_size; kx++) begin
					sum += frame[ci * image_size + (r + ky) * image_width + c + kx] *
						weights[((co * channel_num_in + ci) * kernel_size + ky) *
						kernel_size + kx];
				end
			end
		end
		return sum;
	endfunction

	task automatic report_mismatch(input int index, input int expected, input int actual);
		$display("Fail at time %0t: ch %0d row %0d col %0d expected %0d, got %0d",
			$time, index / out_size, (index % out_size) / out_width,
			index % out_width, expected, actual);
	endtask

	////////////////////////////////////////////////////////////
	// Copy of the accepted weights and image

	always @(posedge clk) begin
		if (reset) begin
			pix_cnt <= 0;
			wt_ptr <= 0;
			busy <= 1'b0;
		end else begin
			// The layer is idle again on the cycle done is high
			if (done)
				busy <= 1'b0;
			if (valid_weight_in && (!busy || done) && pix_cnt == 0) begin
				weights[wt_ptr] <= weight_in;
				wt_ptr <= (wt_ptr == weight_words - 1) ? 0 : wt_ptr + 1;
			end
			if (valid_in && (!busy || done)) begin
				frame[pix_cnt] <= pxl_in;
				if (pix_cnt == frame_words - 1) begin
					pix_cnt <= 0;
					busy <= 1'b1;
				end else begin
					pix_cnt <= pix_cnt + 1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Output comparison

	always @(posedge clk) begin : compare
		int expected;
		if (reset) begin
			out_idx <= 0;
			done_q <= 1'b0;
		end else begin
			done_q <= done;
			if (valid_out) begin
				if (!busy || out_idx >= out_total) begin
					$display("Error at time %0t: valid_out came with no output pending",
						$time);
					fail_count++;
				end else begin
					expected = expected_pixel(out_idx);
					if (int'(pxl_out) == expected) begin
						pass_count++;
					end else begin
						report_mismatch(out_idx, expected, int'(pxl_out));
						fail_count++;
					end
				end
				out_idx <= out_idx + 1;
			end
			if (done) begin
				if (done_q) begin
					$display("Error at time %0t: done stayed high for more than one cycle",
						$time);
					fail_count++;
				end else if (!busy) begin
					$display("Error at time %0t: done pulsed with no frame in replay", $time);
					fail_count++;
				end else if (out_idx != out_total) begin
					$display("Error at time %0t: frame ended with %0d outputs instead of %0d",
						$time, out_idx, out_total);
					fail_count++;
				end else begin
					pass_count++;
				end
				out_idx <= 0;
			end
		end
	end

	// Run length limit
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		timed_out <= (cycle_cnt >= cycle_limit);
	end

endmodule

`default_nettype wire

// File: test/conv_layer_tb.sv
`default_nettype none

module conv_layer_tb import conv_geometry_pkg::*, conv_types_pkg::*; ();

	// Replay length plus pipeline slack
	localparam int done_limit = replay_words + 100;

	logic clk;
	logic reset;
	logic valid_in;
	pixel_t pxl_in;
	logic valid_weight_in;
	weight_t weight_in;
	accum_t pxl_out;
	logic valid_out;
	logic done;
	logic timed_out;
	int pass_count;
	int fail_count;
	int tb_errors;
	int fails_at_start;
	int seed;

	conv_layer_top conv_layer_top_inst (
		.clk(clk),
		.reset(reset),
		.valid_in(valid_in),
		.pxl_in(pxl_in),
		.valid_weight_in(valid_weight_in),
		.weight_in(weight_in),
		.pxl_out(pxl_out),
		.valid_out(valid_out),
		.done(done)
	);

	conv_layer_checker conv_layer_checker_inst (
		.clk(clk),
		.reset(reset),
		.valid_in(valid_in),
		.pxl_in(pxl_in),
		.valid_weight_in(valid_weight_in),
		.weight_in(weight_in),
		.valid_out(valid_out),
		.pxl_out(pxl_out),
		.done(done),
		.pass_count(pass_count),
		.fail_count(fail_count),
		.timed_out(timed_out)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	function automatic int random_byte();
		return ($random(seed) & 255) - 128;
	endfunction

	////////////////////////////////////////////////////////////
	// Stimulus driven on the falling edge

	// Mode 0 loads all ones, otherwise random with both extremes
	task automatic send_weights(input int mode);
		int w;
		for (int i = 0; i < weight_words; i++) begin
			if (mode == 0)
				w = 1;
			else if (i % 5 == 0)
				w = -128;
			else if (i % 7 == 3)
				w = 127;
			else
				w = random_byte();
			@(negedge clk);
			valid_in = 1'b0;
			valid_weight_in = 1'b1;
			weight_in = weight_t'(w);
		end
	endtask

	// Mode 0 sends row plus column
	// max_gap masks the random number of idle cycles
	task automatic send_frame(input int mode, input int max_gap);
		int value;
		int gap;
		for (int i = 0; i < frame_words; i++) begin
			gap = $random(seed) & max_gap;
			repeat (gap) begin
				@(negedge clk);
				valid_in = 1'b0;
				valid_weight_in = 1'b0;
				pxl_in = pixel_t'(random_byte());
			end
			if (mode == 0)
				value = (i % image_size) / image_width + i % image_width;
			else if (i % 9 == 0)
				value = -128;
			else if (i % 13 == 4)
				value = 127;
			else
				value = random_byte();
			@(negedge clk);
			valid_weight_in = 1'b0;
			valid_in = 1'b1;
			pxl_in = pixel_t'(value);
		end
	endtask

	// Noise drives junk pixels and weights while the layer replays
	task automatic wait_done(input bit noise);
		int cycles;
		cycles = 0;
		while (!done && cycles < done_limit) begin
			@(negedge clk);
			if (noise && !done) begin
				valid_in = ($random(seed) & 1) != 0;
				valid_weight_in = ($random(seed) & 1) != 0;
				pxl_in = pixel_t'(random_byte());
				weight_in = weight_t'(random_byte());
			end else begin
				valid_in = 1'b0;
				valid_weight_in = 1'b0;
			end
			cycles++;
		end
		if (!done) begin
			$display("Error at time %0t: done did not arrive within %0d cycles",
				$time, done_limit);
			tb_errors++;
		end else begin
			// Checker samples done on the next rising edge
			idle_cycles(1);
		end
	endtask

	task automatic wait_outputs(input int count);
		int seen;
		int cycles;
		seen = 0;
		cycles = 0;
		while (seen < count && cycles < done_limit) begin
			@(negedge clk);
			valid_in = 1'b0;
			valid_weight_in = 1'b0;
			if (valid_out)
				seen++;
			cycles++;
		end
		if (seen < count) begin
			$display("Error at time %0t: only %0d of %0d outputs arrived",
				$time, seen, count);
			tb_errors++;
		end
	endtask

	task automatic idle_cycles(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			valid_in = 1'b0;
			valid_weight_in = 1'b0;
		end
	endtask

	task automatic end_test(input int num, input string name);
		int failed;
		failed = fail_count + tb_errors - fails_at_start;
		if (failed == 0)
			$display("Test %0d, %s: passed", num, name);
		else
			$display("Test %0d, %s: %0d checks failed", num, name, failed);
		fails_at_start = fail_count + tb_errors;
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		seed = 62364;
		tb_errors = 0;
		fails_at_start = 0;
		reset = 1'b1;
		valid_in = 1'b0;
		pxl_in = '0;
		valid_weight_in = 1'b0;
		weight_in = '0;
		repeat (8) @(negedge clk);
		reset = 1'b0;

		send_weights(0);
		send_frame(0, 0);
		wait_done(0);
		end_test(1, "unit weights and row plus column pixels");

		send_weights(1);
		send_frame(1, 0);
		wait_done(0);
		end_test(2, "random signed data with extremes");

		send_weights(1);
		send_frame(1, 3);
		wait_done(0);
		end_test(3, "random gaps on valid_in");

		send_weights(1);
		send_frame(1, 0);
		wait_done(1);
		end_test(4, "inputs driven during replay");

		send_weights(1);
		send_frame(1, 0);
		wait_done(0);
		send_weights(1);
		send_frame(1, 1);
		wait_done(0);
		end_test(5, "weight reload between frames");

		// Abort a frame partway through its output
		send_weights(1);
		send_frame(1, 0);
		wait_outputs(10);
		reset = 1'b1;
		idle_cycles(3);
		reset = 1'b0;
		idle_cycles(30);
		send_weights(1);
		send_frame(1, 0);
		wait_done(0);
		end_test(6, "reset in the middle of a frame");

		idle_cycles(4);
		$display("Checks passed: %0d, failed: %0d", pass_count, fail_count + tb_errors);
		if (fail_count == 0 && tb_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	always @(posedge clk) begin
		if (timed_out) begin
			$display("Timeout: the run passed its cycle limit and was stopped");
			$display("Checks passed: %0d, failed: %0d", pass_count, fail_count + tb_errors);
			$display("** FAIL **");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: compile.f
source/conv_geometry_pkg.sv
source/conv_types_pkg.sv
source/conv_sequencer.sv
source/input_replay_buffer.sv
source/line_window.sv
source/weight_store.sv
source/mac_array.sv
source/channel_accumulator.sv
source/conv_layer_top.sv
test/conv_layer_checker.sv
test/conv_layer_tb.sv

// File: Bender.yml
package:
  name: conv_layer

sources:
  # Packages first, then the datapath blocks and the top level
  - source/conv_geometry_pkg.sv
  - source/conv_types_pkg.sv
  - source/conv_sequencer.sv
  - source/input_replay_buffer.sv
  - source/line_window.sv
  - source/weight_store.sv
  - source/mac_array.sv
  - source/channel_accumulator.sv
  - source/conv_layer_top.sv

  # Testbench, top module conv_layer_tb
  - target: test
    files:
      - test/conv_layer_checker.sv
      - test/conv_layer_tb.sv
